// File: build.f
+incdir+.
spi_pkg.sv
spi_regs.sv
spi_shift_engine.sv
spi_host.sv
tb_spi_clock.sv
tb_spi_slave_model.sv
tb_spi_host.sv

// File: Makefile
# Verilator build for the SPI master and its testbench

VERILATOR   ?= verilator
TOP         ?= tb_spi_host
FILELIST    ?= build.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_TEXT   ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_spi_host.sv
`include "spi_config.svh"

module tb_spi_host;

   localparam int TIMEOUT = 4000;

   logic        clk;
   logic        rst;
   logic        stb;
   logic        we;
   logic [2:0]  adr;
   logic [31:0] dat_w;
   logic [31:0] dat_r;
   logic        irq;
   logic        sclk;
   logic        mosi;
   logic        miso;

   logic                       slv_cpol;
   logic                       slv_cpha;
   logic                       slv_arm;
   logic [`SPI_DATA_WIDTH-1:0] slv_next;
   logic [`SPI_DATA_WIDTH-1:0] slv_rx;
   logic [15:0]                slv_edges;

   integer seed = 32'h884b;
   int     errors = 0;
   int     checks = 0;
   int     tests = 0;
   int     cyc = 0;
   int     last_edge_cyc = 0;
   logic [15:0] prev_edges = '0;

   logic [`SPI_DATA_WIDTH-1:0] rx_q[$];  // bytes seen by the slave in order of arrival
   int                         gap_q[$]; // clocks between sampling edges

   tb_spi_clock i_tb_spi_clock (.clk_o(clk), .rst_o(rst));

   spi_host i_spi_host
   (
      .clk_i  (clk),
      .rst_i  (rst),
      .stb_i  (stb),
      .we_i   (we),
      .adr_i  (adr),
      .dat_i  (dat_w),
      .dat_o  (dat_r),
      .int_o  (irq),
      .sclk_o (sclk),
      .mosi_o (mosi),
      .miso_i (miso)
   );

   tb_spi_slave_model i_tb_spi_slave_model
   (
      .clk_i       (clk),
      .rst_i       (rst),
      .sclk_i      (sclk),
      .mosi_i      (mosi),
      .cpol_i      (slv_cpol),
      .cpha_i      (slv_cpha),
      .arm_i       (slv_arm),
      .next_byte_i (slv_next),
      .miso_o      (miso),
      .rx_byte_o   (slv_rx),
      .edge_cnt_o  (slv_edges)
   );

   // collects finished slave bytes and edge spacing
   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (slv_edges != prev_edges && slv_edges != 16'd0)
      begin
         if (slv_edges > 16'd1)
            gap_q.push_back(cyc - last_edge_cyc);
         last_edge_cyc <= cyc;
         if (slv_edges[2:0] == 3'd0)
            rx_q.push_back(slv_rx);
      end
      prev_edges <= slv_edges;
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got == exp)
      else
      begin
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("ERROR: %s", msg);
      errors++;
   endtask

   task automatic write_reg(input logic [2:0] a, input logic [31:0] d);
      @(posedge clk);
      stb   <= 1'b1;
      we    <= 1'b1;
      adr   <= a;
      dat_w <= d;
      @(posedge clk);
      stb <= 1'b0;
      we  <= 1'b0;
   endtask

   // read data is combinational, so it is taken mid-cycle
   task automatic read_reg(input logic [2:0] a, output logic [31:0] d);
      @(posedge clk);
      stb <= 1'b1;
      we  <= 1'b0;
      adr <= a;
      @(negedge clk);
      d = dat_r;
   endtask

   task automatic wait_status(input int b, input logic v, input string what);
      logic [31:0] st;
      int n;
      n = 0;
      read_reg(spi_pkg::SPI_ADR_IRQ, st);
      while (st[b] != v && n < TIMEOUT)
      begin
         read_reg(spi_pkg::SPI_ADR_IRQ, st);
         n++;
      end
      if (st[b] != v)
         report_error({"timeout while waiting for ", what});
   endtask

   task automatic arm_slave(input logic [1:0] mode, input logic [7:0] first, input logic [7:0] nxt);
      @(posedge clk);
      slv_cpol <= mode[1];
      slv_cpha <= mode[0];
      slv_next <= first;
      slv_arm  <= 1'b1;
      @(posedge clk);
      slv_arm  <= 1'b0;
      slv_next <= nxt;
   endtask

   task automatic settle_cycles();
      repeat (2) @(posedge clk);
      @(negedge clk);
   endtask

   function automatic logic model_int(input logic [1:0] st, input logic [1:0] en);
      return (st[1] & en[1]) | (st[0] & en[0]);
   endfunction

   task automatic finish_test(input string name, input int err_before);
      tests++;
      if (errors == err_before)
         $display("test %s: pass", name);
      else
         $display("test %s: %0d errors", name, errors - err_before);
   endtask

   task automatic setup_mode(input logic [1:0] mode, input logic [7:0] div);
      write_reg(spi_pkg::SPI_ADR_CTRL, {30'd0, mode});
      write_reg(spi_pkg::SPI_ADR_DIV, {24'd0, div});
   endtask

   task automatic run_single(input logic [1:0] mode, input logic [7:0] div,
                             input logic [7:0] b, input logic [7:0] s);
      int base;
      logic [31:0] v;
      setup_mode(mode, div);
      arm_slave(mode, s, s);
      base = rx_q.size();
      write_reg(spi_pkg::SPI_ADR_TXBUF, {24'd0, b});
      wait_status(0, 1'b0, "engine busy");
      wait_status(0, 1'b1, "engine empty");
      settle_cycles();
      check_val("slave byte count", 32'(rx_q.size() - base), 32'd1);
      if (rx_q.size() > base)
         check_val("mosi byte", {24'd0, rx_q[base]}, {24'd0, b});
      check_val("sampling edges", {16'd0, slv_edges}, 32'd8);
      check_val("sclk_o", {31'd0, sclk}, {31'd0, mode[1]});
      read_reg(spi_pkg::SPI_ADR_RXDATA, v);
      check_val("RXDATA", v, {24'd0, s});
   endtask

   initial
   begin
      int e0;
      int n;
      int base;
      logic [31:0] v;
      logic [31:0] r;
      logic [1:0] mode;
      logic [7:0] div;
      logic [7:0] b1;
      logic [7:0] b2;
      logic [7:0] s1;
      logic [7:0] s2;

      stb      = 1'b0;
      we       = 1'b0;
      adr      = '0;
      dat_w    = '0;
      slv_cpol = 1'b0;
      slv_cpha = 1'b0;
      slv_arm  = 1'b0;
      slv_next = '0;

      n = 0;
      @(posedge clk);
      while (rst !== 1'b0 && n < 100)
      begin
         @(posedge clk);
         n++;
      end
      if (rst !== 1'b0)
         report_error("reset never released");

      // reset values and register read back
      e0 = errors;
      @(negedge clk);
      check_val("sclk_o", {31'd0, sclk}, 32'd0);
      check_val("mosi_o", {31'd0, mosi}, 32'd0);
      check_val("int_o", {31'd0, irq}, 32'd0);
      read_reg(spi_pkg::SPI_ADR_CTRL, v);
      check_val("CTRL", v, 32'd0);
      read_reg(spi_pkg::SPI_ADR_IRQ, v);
      check_val("IRQ status", v, 32'd3);
      read_reg(spi_pkg::SPI_ADR_DIV, v);
      check_val("DIV", v, 32'(`SPI_DIV_RESET));
      read_reg(spi_pkg::SPI_ADR_TXBUF, v);
      check_val("TXBUF", v, 32'd0);
      read_reg(3'd5, v);
      check_val("unmapped read", v, 32'd0);
      r = $random(seed);
      write_reg(spi_pkg::SPI_ADR_DIV, r);
      read_reg(spi_pkg::SPI_ADR_DIV, v);
      check_val("DIV", v, r & 32'hff);
      r = $random(seed);
      write_reg(spi_pkg::SPI_ADR_CTRL, r);
      read_reg(spi_pkg::SPI_ADR_CTRL, v);
      check_val("CTRL", v, r & 32'h3);
      finish_test("reset", e0);

      e0 = errors;
      repeat (24)
      begin
         mode = 2'($random(seed));
         div  = 8'($random(seed) & 3);
         run_single(mode, div, 8'($random(seed)), 8'($random(seed)));
      end
      finish_test("single", e0);

      // second byte is queued as soon as the buffer frees up
      e0 = errors;
      mode = 2'($random(seed));
      div  = 8'($random(seed) & 3);
      b1 = 8'($random(seed));
      b2 = 8'($random(seed));
      s1 = 8'($random(seed));
      s2 = 8'($random(seed));
      setup_mode(mode, div);
      arm_slave(mode, s1, s2);
      base = rx_q.size();
      write_reg(spi_pkg::SPI_ADR_TXBUF, {24'd0, b1});
      wait_status(1, 1'b1, "buffer ready");
      write_reg(spi_pkg::SPI_ADR_TXBUF, {24'd0, b2});
      n = 0;
      read_reg(spi_pkg::SPI_ADR_IRQ, v);
      while (!v[0] && n < TIMEOUT)
      begin
         read_reg(spi_pkg::SPI_ADR_IRQ, v);
         n++;
      end
      if (!v[0])
         report_error("timeout while waiting for the end of two bytes");
      check_val("edges at engine empty", {16'd0, slv_edges}, 32'd16);
      settle_cycles();
      check_val("slave byte count", 32'(rx_q.size() - base), 32'd2);
      if (rx_q.size() >= base + 2)
      begin
         check_val("first mosi byte", {24'd0, rx_q[base]}, {24'd0, b1});
         check_val("second mosi byte", {24'd0, rx_q[base + 1]}, {24'd0, b2});
      end
      read_reg(spi_pkg::SPI_ADR_TXBUF, v);
      check_val("TXBUF", v, {24'd0, s1});
      read_reg(spi_pkg::SPI_ADR_RXDATA, v);
      check_val("RXDATA", v, {24'd0, s2});
      finish_test("back_to_back", e0);

      e0 = errors;
      mode = 2'($random(seed));
      b1 = 8'($random(seed));
      b2 = 8'($random(seed));
      setup_mode(mode, 8'd3);
      arm_slave(mode, 8'($random(seed)), 8'($random(seed)));
      base = rx_q.size();
      write_reg(spi_pkg::SPI_ADR_TXBUF, {24'd0, b1});
      wait_status(1, 1'b1, "buffer ready");
      write_reg(spi_pkg::SPI_ADR_TXBUF, 32'($random(seed)) & 32'hff);
      write_reg(spi_pkg::SPI_ADR_TXBUF, {24'd0, b2});
      wait_status(0, 1'b1, "engine empty");
      settle_cycles();
      check_val("slave byte count", 32'(rx_q.size() - base), 32'd2);
      if (rx_q.size() >= base + 2)
      begin
         check_val("first mosi byte", {24'd0, rx_q[base]}, {24'd0, b1});
         check_val("second mosi byte", {24'd0, rx_q[base + 1]}, {24'd0, b2});
      end
      finish_test("overwrite", e0);

      e0 = errors;
      setup_mode(2'd0, 8'd7);
      for (int en = 0; en < 4; en++)
      begin
         write_reg(spi_pkg::SPI_ADR_IRQ, 32'(en));
         read_reg(spi_pkg::SPI_ADR_IRQ, v);
         check_val("IRQ status idle", v, 32'd3);
         check_val("int_o idle", {31'd0, irq}, {31'd0, model_int(2'b11, 2'(en))});
         arm_slave(2'd0, 8'($random(seed)), 8'($random(seed)));
         write_reg(spi_pkg::SPI_ADR_TXBUF, 32'($random(seed)) & 32'hff);
         wait_status(1, 1'b1, "buffer ready");
         check_val("int_o busy empty", {31'd0, irq}, {31'd0, model_int(2'b10, 2'(en))});
         write_reg(spi_pkg::SPI_ADR_TXBUF, 32'($random(seed)) & 32'hff);
         read_reg(spi_pkg::SPI_ADR_IRQ, v);
         check_val("IRQ status busy full", v, 32'd0);
         check_val("int_o busy full", {31'd0, irq}, {31'd0, model_int(2'b00, 2'(en))});
         wait_status(0, 1'b1, "engine empty");
      end
      write_reg(spi_pkg::SPI_ADR_IRQ, 32'd0);
      finish_test("interrupt", e0);

      e0 = errors;
      repeat (6)
      begin
         mode = 2'($random(seed));
         div  = 8'($random(seed) & 15);
         // a new idle level can look like a sampling edge to the slave before it is armed
         setup_mode(mode, div);
         settle_cycles();
         base = gap_q.size();
         run_single(mode, div, 8'($random(seed)), 8'($random(seed)));
         check_val("edge gap count", 32'(gap_q.size() - base), 32'd7);
         for (int i = base; i < gap_q.size(); i++)
            check_val("edge gap", 32'(gap_q[i]), 32'(2 * (int'(div) + 1)));
      end
      finish_test("bit_rate", e0);

      $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// File: tb_spi_slave_model.sv
`include "spi_config.svh"

// oversampling SPI slave, sclk edges are seen one clock after they happen
module tb_spi_slave_model
(
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        sclk_i,
   input  logic                        mosi_i,
   input  logic                        cpol_i,
   input  logic                        cpha_i,
   input  logic                        arm_i,
   input  logic [`SPI_DATA_WIDTH-1:0]  next_byte_i,
   output logic                        miso_o,
   output logic [`SPI_DATA_WIDTH-1:0]  rx_byte_o,
   output logic [15:0]                 edge_cnt_o
);

   logic                       sclk_q;
   logic [`SPI_DATA_WIDTH-1:0] tx_q;
   logic [`SPI_DATA_WIDTH-1:0] rx_q;
   logic [`SPI_BC_WIDTH-1:0]   bitpos_q;
   logic [15:0]                cnt_q;
   logic                       trail_lvl;
   logic                       into_trail;
   logic                       leave_trail;

   assign trail_lvl   = ~(cpol_i ^ cpha_i);
   assign into_trail  = (sclk_i == trail_lvl) && (sclk_q != trail_lvl);
   assign leave_trail = (sclk_i != trail_lvl) && (sclk_q == trail_lvl);

   always @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         sclk_q   <= 1'b0;
         tx_q     <= '0;
         rx_q     <= '0;
         bitpos_q <= '0;
         cnt_q    <= '0;
      end
      else
      begin
         sclk_q <= sclk_i;
         if (arm_i)
         begin
            tx_q     <= next_byte_i;
            rx_q     <= '0;
            bitpos_q <= '0;
            cnt_q    <= '0;
         end
         else if (into_trail)
         begin
            rx_q     <= {rx_q[`SPI_DATA_WIDTH-2:0], mosi_i};  // sampling edge
            bitpos_q <= bitpos_q + 1'b1;
            cnt_q    <= cnt_q + 16'd1;
         end
         else if (leave_trail)
         begin
            // at a byte boundary the next queued byte takes over, before the first bit nothing moves
            if (bitpos_q == '0)
            begin
               if (cnt_q != 16'd0)
                  tx_q <= next_byte_i;
            end
            else
               tx_q <= {tx_q[`SPI_DATA_WIDTH-2:0], 1'b0};
         end
      end
   end

   assign miso_o     = tx_q[`SPI_DATA_WIDTH-1];
   assign rx_byte_o  = rx_q;
   assign edge_cnt_o = cnt_q;

endmodule

// File: tb_spi_clock.sv
module tb_spi_clock
(
   output logic clk_o,
   output logic rst_o
);

   localparam int HALF_PERIOD  = 2;
   localparam int RESET_CYCLES = 5;

   initial
   begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   initial
   begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

// File: spi_host.sv
`include "spi_config.svh"

module spi_host
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [2:0]  adr_i,
   input  logic [31:0] dat_i,
   output logic [31:0] dat_o,
   output logic        int_o,
   output logic        sclk_o,
   output logic        mosi_o,
   input  logic        miso_i
);

   logic [`SPI_DATA_WIDTH-1:0] tx_byte;
   logic [`SPI_DATA_WIDTH-1:0] rx_byte;
   logic [`SPI_DATA_WIDTH-1:0] shift_byte;
   logic [`SPI_DIV_WIDTH-1:0]  div;
   logic                       buf_full;
   logic                       cpol;
   logic                       cpha;
   logic                       load;
   logic                       idle;

   spi_regs i_spi_regs
   (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .stb_i        (stb_i),
      .we_i         (we_i),
      .adr_i        (adr_i),
      .dat_i        (dat_i),
      .load_i       (load),
      .rx_byte_i    (rx_byte),
      .idle_i       (idle),
      .shift_byte_i (shift_byte),
      .dat_o        (dat_o),
      .int_o        (int_o),
      .tx_byte_o    (tx_byte),
      .buf_full_o   (buf_full),
      .cpol_o       (cpol),
      .cpha_o       (cpha),
      .div_o        (div)
   );

   spi_shift_engine i_spi_shift_engine
   (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .tx_byte_i    (tx_byte),
      .buf_full_i   (buf_full),
      .cpol_i       (cpol),
      .cpha_i       (cpha),
      .div_i        (div),
      .miso_i       (miso_i),
      .load_o       (load),
      .rx_byte_o    (rx_byte),
      .idle_o       (idle),
      .shift_byte_o (shift_byte),
      .sclk_o       (sclk_o),
      .mosi_o       (mosi_o)
   );

endmodule

// File: spi_shift_engine.sv
`include "spi_config.svh"

module spi_shift_engine
(
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic [`SPI_DATA_WIDTH-1:0]  tx_byte_i,
   input  logic                        buf_full_i,
   input  logic                        cpol_i,
   input  logic                        cpha_i,
   input  logic [`SPI_DIV_WIDTH-1:0]   div_i,
   input  logic                        miso_i,
   output logic                        load_o,
   output logic [`SPI_DATA_WIDTH-1:0]  rx_byte_o,
   output logic                        idle_o,
   output logic [`SPI_DATA_WIDTH-1:0]  shift_byte_o,
   output logic                        sclk_o,
   output logic                        mosi_o
);

   localparam logic [`SPI_BC_WIDTH-1:0] LAST_BIT = `SPI_BC_WIDTH'(`SPI_DATA_WIDTH - 1);

   spi_pkg::spi_state_e state_q;
   spi_pkg::spi_state_e state_d;

   logic [`SPI_DIV_WIDTH-1:0]  rate_q;
   logic [`SPI_DIV_WIDTH-1:0]  rate_d;
   logic [`SPI_BC_WIDTH-1:0]   bit_q;
   logic [`SPI_BC_WIDTH-1:0]   bit_d;
   logic [`SPI_DATA_WIDTH-1:0] shift_q;
   logic [`SPI_DATA_WIDTH-1:0] shift_d;
   logic [`SPI_DATA_WIDTH-1:0] shift_in;
   logic                       sclk_q;
   logic                       sclk_d;
   logic                       phase_done;
   logic                       load;

   assign shift_in   = {shift_q[`SPI_DATA_WIDTH-2:0], miso_i};  // left shift with miso in the LSB
   assign phase_done = (rate_q == '0);

   always_comb
   begin
      state_d = state_q;
      rate_d  = rate_q;
      bit_d   = bit_q;
      shift_d = shift_q;
      load    = 1'b0;
      case (state_q)
         spi_pkg::SPI_IDLE:
         begin
            if (buf_full_i)
            begin
               load    = 1'b1;
               shift_d = tx_byte_i;
               bit_d   = LAST_BIT;
               rate_d  = div_i;
               state_d = spi_pkg::SPI_LEAD;
            end
         end
         spi_pkg::SPI_LEAD:
         begin
            if (phase_done)
            begin
               rate_d  = div_i;  // divider is taken fresh at every phase start
               state_d = spi_pkg::SPI_TRAIL;
            end
            else
               rate_d = rate_q - 1'b1;
         end
         spi_pkg::SPI_TRAIL:
         begin
            if (!phase_done)
               rate_d = rate_q - 1'b1;
            else
            begin
               shift_d = shift_in;
               bit_d   = bit_q - 1'b1;
               rate_d  = div_i;
               if (bit_q != '0)
                  state_d = spi_pkg::SPI_LEAD;
               else if (buf_full_i)
               begin
                  // next byte follows without an idle gap
                  load    = 1'b1;
                  shift_d = tx_byte_i;
                  bit_d   = LAST_BIT;
                  state_d = spi_pkg::SPI_LEAD;
               end
               else
                  state_d = spi_pkg::SPI_IDLE;
            end
         end
         default:
         begin
            state_d = spi_pkg::SPI_IDLE;
         end
      endcase
   end

   // the edge into the trail level is the sampling edge in every mode
   always_comb
   begin
      case (state_d)
         spi_pkg::SPI_LEAD:  sclk_d = cpol_i ^ cpha_i;
         spi_pkg::SPI_TRAIL: sclk_d = ~(cpol_i ^ cpha_i);
         default:            sclk_d = cpol_i;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         state_q <= spi_pkg::SPI_IDLE;
         rate_q  <= '0;
         bit_q   <= '0;
         shift_q <= '0;
         sclk_q  <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         rate_q  <= rate_d;
         bit_q   <= bit_d;
         shift_q <= shift_d;
         sclk_q  <= sclk_d;
      end
   end

   // at a back-to-back load the buffer gets the byte with its final bit shifted in
   assign rx_byte_o = (state_q == spi_pkg::SPI_IDLE) ? shift_q : shift_in;

   assign load_o       = load;
   assign idle_o       = (state_q == spi_pkg::SPI_IDLE);
   assign shift_byte_o = shift_q;
   assign sclk_o       = sclk_q;
   assign mosi_o       = shift_q[`SPI_DATA_WIDTH-1];  // MSB first

endmodule

// File: spi_regs.sv
`include "spi_config.svh"

module spi_regs
(
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        stb_i,
   input  logic                        we_i,
   input  logic [2:0]                  adr_i,
   input  logic [31:0]                 dat_i,
   input  logic                        load_i,
   input  logic [`SPI_DATA_WIDTH-1:0]  rx_byte_i,
   input  logic                        idle_i,
   input  logic [`SPI_DATA_WIDTH-1:0]  shift_byte_i,
   output logic [31:0]                 dat_o,
   output logic                        int_o,
   output logic [`SPI_DATA_WIDTH-1:0]  tx_byte_o,
   output logic                        buf_full_o,
   output logic                        cpol_o,
   output logic                        cpha_o,
   output logic [`SPI_DIV_WIDTH-1:0]   div_o
);

   spi_pkg::spi_addr_e adr;

   logic wr;
   logic wr_txbuf;
   logic wr_irq;
   logic wr_ctrl;
   logic wr_div;

   logic [`SPI_DATA_WIDTH-1:0] txbuf_q;
   logic                       buf_full_q;
   logic                       cpol_q;
   logic                       cpha_q;
   logic [`SPI_DIV_WIDTH-1:0]  div_q;
   logic                       ready_en_q;
   logic                       empty_en_q;

   logic buf_ready;

   assign adr = spi_pkg::spi_addr_e'(adr_i);

   assign wr       = stb_i & we_i;
   assign wr_txbuf = wr & (adr == spi_pkg::SPI_ADR_TXBUF);
   assign wr_irq   = wr & (adr == spi_pkg::SPI_ADR_IRQ);
   assign wr_ctrl  = wr & (adr == spi_pkg::SPI_ADR_CTRL);  // only its own address
   assign wr_div   = wr & (adr == spi_pkg::SPI_ADR_DIV);

   // the buffer swaps with the engine on load, so after a reload it holds the received byte
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         txbuf_q    <= '0;
         buf_full_q <= 1'b0;
      end
      else if (wr_txbuf)
      begin
         txbuf_q    <= dat_i[`SPI_DATA_WIDTH-1:0];  // a repeated write replaces the pending byte
         buf_full_q <= 1'b1;
      end
      else if (load_i)
      begin
         txbuf_q    <= rx_byte_i;
         buf_full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         cpol_q     <= 1'b0;
         cpha_q     <= 1'b0;
         div_q      <= `SPI_DIV_WIDTH'(`SPI_DIV_RESET);
         ready_en_q <= 1'b0;
         empty_en_q <= 1'b0;
      end
      else
      begin
         if (wr_ctrl)
         begin
            cpol_q <= dat_i[1];
            cpha_q <= dat_i[0];
         end
         if (wr_div)
            div_q <= dat_i[`SPI_DIV_WIDTH-1:0];
         if (wr_irq)
         begin
            ready_en_q <= dat_i[1];
            empty_en_q <= dat_i[0];
         end
      end
   end

   assign buf_ready = ~buf_full_q;

   // read data follows adr_i without a clock
   always_comb
   begin
      dat_o = '0;
      case (adr)
         spi_pkg::SPI_ADR_RXDATA: dat_o[`SPI_DATA_WIDTH-1:0] = shift_byte_i;
         spi_pkg::SPI_ADR_TXBUF:  dat_o[`SPI_DATA_WIDTH-1:0] = txbuf_q;
         spi_pkg::SPI_ADR_IRQ:    dat_o[1:0] = {buf_ready, idle_i};
         spi_pkg::SPI_ADR_CTRL:   dat_o[1:0] = {cpol_q, cpha_q};
         spi_pkg::SPI_ADR_DIV:    dat_o[`SPI_DIV_WIDTH-1:0] = div_q;
         default:                 dat_o = '0;  // unmapped addresses read as zero
      endcase
   end

   assign int_o = (buf_ready & ready_en_q) | (idle_i & empty_en_q);  // level interrupt

   assign tx_byte_o  = txbuf_q;
   assign buf_full_o = buf_full_q;
   assign cpol_o     = cpol_q;
   assign cpha_o     = cpha_q;
   assign div_o      = div_q;

endmodule

// File: spi_pkg.sv
package spi_pkg;

   // sequencer phases of the shift engine
   typedef enum logic [1:0]
   {
      SPI_IDLE  = 2'd0,  // no transfer, sclk parked at cpol
      SPI_LEAD  = 2'd1,  // first half of a bit
      SPI_TRAIL = 2'd2   // second half, miso sampled on its last clock
   } spi_state_e;

   // register port addresses
   typedef enum logic [2:0]
   {
      SPI_ADR_RXDATA = 3'd0,
      SPI_ADR_TXBUF  = 3'd1,
      SPI_ADR_IRQ    = 3'd2,
      SPI_ADR_CTRL   = 3'd3,
      SPI_ADR_DIV    = 3'd4
   } spi_addr_e;

endpackage

// File: spi_config.svh
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// width of one transferred word, also the width of RXDATA and TXBUF
`define SPI_DATA_WIDTH 8

// divider register and bit-rate counter width
`define SPI_DIV_WIDTH 8

// bit counter, must reach SPI_DATA_WIDTH-1
`define SPI_BC_WIDTH 3

// half-bit length minus one after reset
`define SPI_DIV_RESET 1

`endif
